/* src.f */
design/ext_mem_pkg.sv
design/l1_cache.sv
design/bus_merge.sv
design/ext_mem.sv
dv/mem_model.sv
dv/ext_mem_assertions.sv
dv/ext_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ext_mem_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/ext_mem_tb.sv */
module ext_mem_tb;
   import ext_mem_pkg::*;

   localparam int LINE_OFF_W      = 4;
   localparam int WORD_OFF_W      = 2;
   localparam int CLK_PERIOD      = 10;
   localparam int RESET_CYCLES    = 10;
   localparam int N_TESTS         = 5;
   localparam int CYCLES_PER_TEST = 2000;
   localparam int MODEL_WORDS     = 1024;

   // Next tag up on the same line index
   localparam logic [ADDR_W-1:0] CONFLICT_STRIDE =
      ADDR_W'(1 << (LINE_OFF_W + WORD_OFF_W + 2));

   logic      clk;
   logic      rst;
   mem_req_t  i_req;
   mem_resp_t i_resp;
   mem_req_t  d_req;
   mem_resp_t d_resp;
   mem_req_t  mem_req;
   mem_resp_t mem_resp;

   int errors     = 0;
   int checks     = 0;
   int tests_done = 0;

   // Expected memory content
   logic [DATA_W-1:0] shadow [MODEL_WORDS];

   ext_mem #(
      .LINE_OFF_W (LINE_OFF_W),
      .WORD_OFF_W (WORD_OFF_W)
   ) UUT (
      .clk      (clk),
      .rst      (rst),
      .i_req    (i_req),
      .i_resp   (i_resp),
      .d_req    (d_req),
      .d_resp   (d_resp),
      .mem_req  (mem_req),
      .mem_resp (mem_resp)
   );

   mem_model memory (
      .clk  (clk),
      .rst  (rst),
      .req  (mem_req),
      .resp (mem_resp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("TIMEOUT: the tests did not finish within %0d cycles",
               N_TESTS * CYCLES_PER_TEST);
      $display("STATUS: FAIL");
      $finish;
   end

   task automatic check_value(input string what, input logic [DATA_W-1:0] actual,
                              input logic [DATA_W-1:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR at %0t: %s: got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic test_done(input string name, input int errs_before);
      tests_done++;
      $display("test %0d %s: %0d errors", tests_done, name, errors - errs_before);
   endtask

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
      return shadow[addr[11:2]];
   endfunction

   task automatic apply_reset();
      i_req = '0;
      d_req = '0;
      rst   = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
   endtask

   // Entered and left 1 unit after a rising edge
   task automatic data_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic [STRB_W-1:0] wstrb, output logic [DATA_W-1:0] rdata,
                              output int cycles);
      d_req.valid = 1'b1;
      d_req.addr  = addr;
      d_req.wdata = wdata;
      d_req.wstrb = wstrb;
      cycles      = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!d_resp.ready);
      rdata = d_resp.rdata;
      @(posedge clk);
      #1;
      d_req = '0;
   endtask

   task automatic instr_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
      i_req.valid = 1'b1;
      i_req.addr  = addr;
      i_req.wdata = '0;
      i_req.wstrb = '0;
      do begin
         @(negedge clk);
      end while (!i_resp.ready);
      rdata = i_resp.rdata;
      @(posedge clk);
      #1;
      i_req = '0;
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [STRB_W-1:0] wstrb);
      logic [DATA_W-1:0] unused_rdata;
      int                cycles;
      shadow[addr[11:2]] = merge_bytes(shadow[addr[11:2]], wdata, wstrb);
      data_access(addr, wdata, wstrb, unused_rdata, cycles);
   endtask

   task automatic read_miss_then_hit();
      logic [ADDR_W-1:0] addrs [4];
      logic [DATA_W-1:0] rdata;
      int                cycles;
      int                errs_before;
      errs_before = errors;
      addrs = '{24'h000010, 24'h000124, 24'h000308, 24'h00044C};
      for (int pass = 0; pass < 2; pass++) begin
         foreach (addrs[k]) begin
            data_access(addrs[k], '0, '0, rdata, cycles);
            check_value($sformatf("read %h", addrs[k]), rdata, expected_word(addrs[k]));
            // Second pass hits with ready one cycle after the sample
            if (pass == 1) begin
               check_value($sformatf("hit latency %h", addrs[k]), 32'(cycles), 32'd2);
            end
         end
      end
      test_done("read miss then hit", errs_before);
   endtask

   task automatic write_through_strobes();
      logic [ADDR_W-1:0] cached_addr;
      logic [ADDR_W-1:0] uncached_addr;
      logic [DATA_W-1:0] rdata;
      int                cycles;
      int                errs_before;
      errs_before   = errors;
      cached_addr   = 24'h000010;
      uncached_addr = 24'h000600;
      write_word(cached_addr, 32'h11223344, 4'b0101);
      write_word(uncached_addr, 32'hDEADBEEF, 4'b1100);
      check_value("model after cached write", memory.words[cached_addr[11:2]],
                  expected_word(cached_addr));
      check_value("model after uncached write", memory.words[uncached_addr[11:2]],
                  expected_word(uncached_addr));
      data_access(cached_addr, '0, '0, rdata, cycles);
      check_value("merged cached word", rdata, expected_word(cached_addr));
      check_value("merged cached word latency", 32'(cycles), 32'd2);
      data_access(uncached_addr, '0, '0, rdata, cycles);
      check_value("merged word from memory", rdata, expected_word(uncached_addr));
      test_done("write-through with strobes", errs_before);
   endtask

   task automatic line_conflict();
      logic [ADDR_W-1:0] base;
      logic [ADDR_W-1:0] seq [6];
      logic [DATA_W-1:0] rdata;
      int                cycles;
      int                errs_before;
      errs_before = errors;
      base = 24'h000034;
      seq  = '{base, base + CONFLICT_STRIDE, base, base + CONFLICT_STRIDE,
               base + 2 * CONFLICT_STRIDE, base};
      foreach (seq[k]) begin
         data_access(seq[k], '0, '0, rdata, cycles);
         check_value($sformatf("conflict read %h", seq[k]), rdata, expected_word(seq[k]));
      end
      test_done("line conflict", errs_before);
   endtask

   task automatic concurrent_ports();
      logic [ADDR_W-1:0] i_addrs [2];
      logic [ADDR_W-1:0] d_addrs [2];
      logic [DATA_W-1:0] i_data;
      logic [DATA_W-1:0] d_data;
      int                cycles;
      int                errs_before;
      errs_before = errors;
      i_addrs = '{24'h000A04, 24'h000C40};
      d_addrs = '{24'h000B18, 24'h000C50};
      foreach (i_addrs[k]) begin
         fork
            instr_read(i_addrs[k], i_data);
            data_access(d_addrs[k], '0, '0, d_data, cycles);
         join
         check_value($sformatf("instr read %h", i_addrs[k]), i_data, expected_word(i_addrs[k]));
         check_value($sformatf("data read %h", d_addrs[k]), d_data, expected_word(d_addrs[k]));
      end
      test_done("concurrent ports", errs_before);
   endtask

   task automatic hit_after_backdoor_and_reset();
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] old_word;
      logic [DATA_W-1:0] new_word;
      logic [DATA_W-1:0] rdata;
      int                cycles;
      int                errs_before;
      errs_before = errors;
      addr     = 24'h000E2C;
      old_word = expected_word(addr);
      new_word = 32'h0BADF00D;
      data_access(addr, '0, '0, rdata, cycles);
      check_value("first read", rdata, old_word);
      memory.backdoor_write(addr[11:2], new_word);
      shadow[addr[11:2]] = new_word;
      // Still cached so the stale word comes back
      data_access(addr, '0, '0, rdata, cycles);
      check_value("read after backdoor change", rdata, old_word);
      apply_reset();
      data_access(addr, '0, '0, rdata, cycles);
      check_value("read after reset", rdata, new_word);
      test_done("hit after backdoor change, then reset", errs_before);
   endtask

   initial begin
      i_req = '0;
      d_req = '0;
      rst   = 1'b1;
      for (int a = 0; a < MODEL_WORDS; a++) begin
         shadow[a] = a ^ 32'hA5A50000;
      end
      apply_reset();

      read_miss_then_hit();
      write_through_strobes();
      line_conflict();
      concurrent_ports();
      hit_after_backdoor_and_reset();

      $display("tests %0d of %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_done, N_TESTS, checks, errors, UUT.handshake_checks.fail_count);
      if (errors == 0 && UUT.handshake_checks.fail_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* dv/ext_mem_assertions.sv */
module ext_mem_assertions (
   input logic                   clk,
   input logic                   rst,
   input ext_mem_pkg::mem_req_t  i_req,
   input ext_mem_pkg::mem_resp_t i_resp,
   input ext_mem_pkg::mem_req_t  d_req,
   input ext_mem_pkg::mem_resp_t d_resp,
   input ext_mem_pkg::mem_req_t  mem_req,
   input ext_mem_pkg::mem_resp_t mem_resp
);

   int fail_count = 0;

   // Front-end ready only answers a live request
   i_ready_with_valid: assert property (@(posedge clk) disable iff (rst)
      i_resp.ready |-> i_req.valid)
      else begin
         $error("instruction port ready while its valid is low");
         fail_count++;
      end

   d_ready_with_valid: assert property (@(posedge clk) disable iff (rst)
      d_resp.ready |-> d_req.valid)
      else begin
         $error("data port ready while its valid is low");
         fail_count++;
      end

   // Pending memory request holds still until accepted
   mem_req_stable: assert property (@(posedge clk) disable iff (rst)
      mem_req.valid && !mem_resp.ready |=>
         mem_req.valid && $stable(mem_req.addr) && $stable(mem_req.wdata)
         && $stable(mem_req.wstrb))
      else begin
         $error("memory request changed before ready");
         fail_count++;
      end

   // Quiet outputs through reset
   quiet_in_reset: assert property (@(posedge clk)
      rst |=> !i_resp.ready && !d_resp.ready && !mem_req.valid)
      else begin
         $error("ready or memory valid seen during reset");
         fail_count++;
      end

endmodule

bind ext_mem ext_mem_assertions handshake_checks (
   .clk      (clk),
   .rst      (rst),
   .i_req    (i_req),
   .i_resp   (i_resp),
   .d_req    (d_req),
   .d_resp   (d_resp),
   .mem_req  (mem_req),
   .mem_resp (mem_resp)
);

/* dv/mem_model.sv */
module mem_model (
   input  logic                   clk,
   input  logic                   rst,
   input  ext_mem_pkg::mem_req_t  req,
   output ext_mem_pkg::mem_resp_t resp
);
   import ext_mem_pkg::*;

   localparam int N_WORDS = 1024;

   logic [DATA_W-1:0] words [N_WORDS];
   logic              loaded = 1'b0;
   logic [1:0]        wait_cnt;
   integer            seed = 32'h2598;

   // Backdoor writes land on the next clock edge
   int unsigned       bd_count = 0;
   int unsigned       bd_seen = 0;
   logic [9:0]        bd_addr;
   logic [DATA_W-1:0] bd_data;

   logic [9:0] word_idx;

   assign word_idx = req.addr[11:2];

   always @(posedge clk) begin
      // Content at word a is a XOR A5A50000
      if (!loaded) begin
         for (int i = 0; i < N_WORDS; i++) begin
            words[i] <= i ^ 32'hA5A50000;
         end
         loaded <= 1'b1;
      end
      if (bd_count != bd_seen) begin
         words[bd_addr] <= bd_data;
         bd_seen        <= bd_count;
      end
      if (rst) begin
         resp.ready <= 1'b0;
         wait_cnt   <= 2'($unsigned($random(seed)) % 4);
      end else if (resp.ready) begin
         resp.ready <= 1'b0;
      end else if (req.valid) begin
         if (wait_cnt == 2'd0) begin
            resp.ready <= 1'b1;
            resp.rdata <= words[word_idx];
            for (int b = 0; b < STRB_W; b++) begin
               if (req.wstrb[b]) begin
                  words[word_idx][8*b +: 8] <= req.wdata[8*b +: 8];
               end
            end
            // New random latency for the next beat
            wait_cnt <= 2'($unsigned($random(seed)) % 4);
         end else begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

   task automatic backdoor_write(input logic [9:0] waddr, input logic [DATA_W-1:0] value);
      bd_addr  = waddr;
      bd_data  = value;
      bd_count = bd_count + 1;
   endtask

endmodule

/* design/ext_mem.sv */
module ext_mem #(
   parameter int LINE_OFF_W = 4,
   parameter int WORD_OFF_W = 2
) (
   input  logic                   clk,
   input  logic                   rst,

   // Instruction port
   input  ext_mem_pkg::mem_req_t  i_req,
   output ext_mem_pkg::mem_resp_t i_resp,

   // Data port
   input  ext_mem_pkg::mem_req_t  d_req,
   output ext_mem_pkg::mem_resp_t d_resp,

   // External memory
   output ext_mem_pkg::mem_req_t  mem_req,
   input  ext_mem_pkg::mem_resp_t mem_resp
);
   import ext_mem_pkg::*;

   // Cache back ends toward the merge
   mem_req_t  icache_be_req;
   mem_resp_t icache_be_resp;
   mem_req_t  dcache_be_req;
   mem_resp_t dcache_be_resp;

   // Instruction cache
   l1_cache #(
      .LINE_OFF_W (LINE_OFF_W),
      .WORD_OFF_W (WORD_OFF_W)
   ) icache (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (i_req),
      .fe_resp (i_resp),
      .be_req  (icache_be_req),
      .be_resp (icache_be_resp)
   );

   // Data cache, same geometry
   l1_cache #(
      .LINE_OFF_W (LINE_OFF_W),
      .WORD_OFF_W (WORD_OFF_W)
   ) dcache (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (d_req),
      .fe_resp (d_resp),
      .be_req  (dcache_be_req),
      .be_resp (dcache_be_resp)
   );

   // Instruction side wins a tie
   bus_merge merge_i_d (
      .clk     (clk),
      .rst     (rst),
      .m0_req  (icache_be_req),
      .m0_resp (icache_be_resp),
      .m1_req  (dcache_be_req),
      .m1_resp (dcache_be_resp),
      .s_req   (mem_req),
      .s_resp  (mem_resp)
   );

endmodule

/* design/bus_merge.sv */
module bus_merge (
   input  logic                   clk,
   input  logic                   rst,

   // Master 0, higher priority
   input  ext_mem_pkg::mem_req_t  m0_req,
   output ext_mem_pkg::mem_resp_t m0_resp,

   // Master 1
   input  ext_mem_pkg::mem_req_t  m1_req,
   output ext_mem_pkg::mem_resp_t m1_resp,

   // Shared slave
   output ext_mem_pkg::mem_req_t  s_req,
   input  ext_mem_pkg::mem_resp_t s_resp
);
   import ext_mem_pkg::*;

   typedef enum logic [1:0] {
      OWN_NONE,
      OWN_M0,
      OWN_M1
   } owner_t;

   owner_t owner_q;
   owner_t owner_d;
   logic   hold;

   // Owner keeps the bus as long as its valid stays up
   always_comb begin
      case (owner_q)
         OWN_M0:  hold = m0_req.valid;
         OWN_M1:  hold = m1_req.valid;
         default: hold = 1'b0;
      endcase

      if (hold) begin
         owner_d = owner_q;
      end else if (m0_req.valid) begin
         owner_d = OWN_M0;
      end else if (m1_req.valid) begin
         owner_d = OWN_M1;
      end else begin
         owner_d = OWN_NONE;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         owner_q <= OWN_NONE;
      end else begin
         owner_q <= owner_d;
      end
   end

   // Request path, no added cycle
   // With no owner m0 is idle, so its low valid passes through
   assign s_req = (owner_d == OWN_M1) ? m1_req : m0_req;

   // Only the owner sees ready
   always_comb begin
      m0_resp.rdata = s_resp.rdata;
      m0_resp.ready = s_resp.ready && (owner_d == OWN_M0);
      m1_resp.rdata = s_resp.rdata;
      m1_resp.ready = s_resp.ready && (owner_d == OWN_M1);
   end

endmodule

/* design/l1_cache.sv */
module l1_cache #(
   parameter int LINE_OFF_W = 4,
   parameter int WORD_OFF_W = 2
) (
   input  logic                   clk,
   input  logic                   rst,

   // Front end
   input  ext_mem_pkg::mem_req_t  fe_req,
   output ext_mem_pkg::mem_resp_t fe_resp,

   // Back end
   output ext_mem_pkg::mem_req_t  be_req,
   input  ext_mem_pkg::mem_resp_t be_resp
);
   import ext_mem_pkg::*;

   localparam int BYTE_OFF_W = $clog2(STRB_W);
   localparam int TAG_W      = ADDR_W - LINE_OFF_W - WORD_OFF_W - BYTE_OFF_W;
   localparam int N_LINES    = 2 ** LINE_OFF_W;
   localparam int N_WORDS    = 2 ** (LINE_OFF_W + WORD_OFF_W);

   cache_state_t state;

   // Request held while it is in flight
   mem_req_t              req_q;
   logic [DATA_W-1:0]     rdata_q;
   logic [WORD_OFF_W-1:0] beat_cnt;

   // Per-line valid bits, tags and the word store
   logic [N_LINES-1:0] line_valid;
   logic [TAG_W-1:0]   tag_mem  [N_LINES];
   logic [DATA_W-1:0]  data_mem [N_WORDS];

   // Lookup fields
   logic [ADDR_W-1:0]     look_addr;
   logic [TAG_W-1:0]      look_tag;
   logic [LINE_OFF_W-1:0] look_line;
   logic [WORD_OFF_W-1:0] look_word;
   logic                  hit;

   logic is_write;
   logic take_req;
   logic refill_beat;
   logic last_beat;

   // Word store write port
   logic                             mem_we;
   logic [LINE_OFF_W+WORD_OFF_W-1:0] mem_waddr;
   logic [DATA_W-1:0]                mem_wdata;
   logic [STRB_W-1:0]                mem_wstrb;

   // New requests are looked up straight from the port, later states use the held copy
   assign look_addr = (state == IDLE) ? fe_req.addr : req_q.addr;
   assign look_tag  = look_addr[ADDR_W-1 -: TAG_W];
   assign look_line = look_addr[BYTE_OFF_W+WORD_OFF_W +: LINE_OFF_W];
   assign look_word = look_addr[BYTE_OFF_W +: WORD_OFF_W];
   assign hit       = line_valid[look_line] && (tag_mem[look_line] == look_tag);

   assign is_write    = |fe_req.wstrb;
   assign take_req    = (state == IDLE) && fe_req.valid;
   assign refill_beat = (state == REFILL) && be_resp.ready;

   // Refill always runs from word 0 to the end of the line
   assign last_beat = &beat_cnt;

   // Controller
   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         beat_cnt   <= '0;
         line_valid <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (fe_req.valid) begin
                  beat_cnt <= '0;
                  if (is_write) begin
                     state <= WRITE;
                  end else if (hit) begin
                     state <= RESPOND;
                  end else begin
                     state <= REFILL;
                  end
               end
            end
            REFILL: begin
               if (be_resp.ready) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (last_beat) begin
                     line_valid[look_line] <= 1'b1;
                     state                 <= RESPOND;
                  end
               end
            end
            WRITE: begin
               // Write-through, wait for memory to accept
               if (be_resp.ready) begin
                  state <= RESPOND;
               end
            end
            RESPOND: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Held request, response word and tags
   always_ff @(posedge clk) begin
      if (take_req) begin
         req_q <= fe_req;
      end
      if (take_req && !is_write && hit) begin
         rdata_q <= data_mem[{look_line, look_word}];
      end
      // Grab the requested word as it streams past
      if (refill_beat && (beat_cnt == look_word)) begin
         rdata_q <= be_resp.rdata;
      end
      if (refill_beat && last_beat) begin
         tag_mem[look_line] <= look_tag;
      end
   end

   // Word store write select
   always_comb begin
      mem_we    = 1'b0;
      mem_waddr = {look_line, look_word};
      mem_wdata = req_q.wdata;
      mem_wstrb = req_q.wstrb;
      case (state)
         REFILL: begin
            if (be_resp.ready) begin
               mem_we    = 1'b1;
               mem_waddr = {look_line, beat_cnt};
               mem_wdata = be_resp.rdata;
               mem_wstrb = '1;
            end
         end
         WRITE: begin
            // No allocate, only a present line is updated
            mem_we = be_resp.ready && hit;
         end
         default: begin
            mem_we = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (mem_we) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (mem_wstrb[b]) begin
               data_mem[mem_waddr][8*b +: 8] <= mem_wdata[8*b +: 8];
            end
         end
      end
   end

   // Front-end response
   always_comb begin
      fe_resp.rdata = rdata_q;
      fe_resp.ready = (state == RESPOND);
   end

   // Back-end request
   // valid stays up over the whole refill, addr steps after each beat
   always_comb begin
      be_req.valid = (state == REFILL) || (state == WRITE);
      be_req.wdata = req_q.wdata;
      if (state == REFILL) begin
         be_req.addr  = {look_tag, look_line, beat_cnt, {BYTE_OFF_W{1'b0}}};
         be_req.wstrb = '0;
      end else begin
         be_req.addr  = req_q.addr;
         be_req.wstrb = req_q.wstrb;
      end
   end

endmodule

/* design/ext_mem_pkg.sv */
package ext_mem_pkg;

   // Byte address width, same as the DDR address
   localparam int ADDR_W = 24;

   // One data word on every link
   localparam int DATA_W = 32;

   // One strobe per byte lane
   localparam int STRB_W = DATA_W / 8;

   // Native request, valid sits in the top bit
   // A zero wstrb marks a read
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } mem_req_t;

   // Native response
   // ready pulses for one cycle, rdata valid with it on reads
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              ready;
   } mem_resp_t;

   // Cache controller states
   typedef enum logic [1:0] {
      IDLE,
      REFILL,
      WRITE,
      RESPOND
   } cache_state_t;

endpackage
